// ==== source/noc_pkg.sv ====
package noc_pkg;

    // Flit type in the top TYPE_W bits of every flit
    typedef enum logic [1:0] {
        HEAD     = 2'b00,
        DATA     = 2'b01,
        TAIL     = 2'b10,
        HEADTAIL = 2'b11
    } flit_type_e;

    // Packetizer FSM
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        INIT = 2'b01,
        SEND = 2'b10,
        WAIT = 2'b11
    } pktz_state_e;

    localparam int TYPE_W    = 2;
    localparam int FLIT_ID_W = 4;   // Flit id wraps modulo 16
    localparam int TS_W      = 16;

    // Body flit layout, fixed bit positions
    // The timestamp sits below the type field so the type bits stay intact
    localparam int FLIT_ID_LSB = 8;
    localparam int FLIT_ID_MSB = FLIT_ID_LSB + FLIT_ID_W - 1;    // 11
    localparam int TS_LSB      = FLIT_ID_MSB + 1;                // 12
    localparam int TS_MSB      = TS_LSB + TS_W - 1;              // 27

    // Head flit fields follow directly below the type, sized by module parameters:
    // type | dst | src | vch | zero

    function automatic logic starts_packet(flit_type_e t);
        return (t == HEAD) || (t == HEADTAIL);
    endfunction

    function automatic logic ends_packet(flit_type_e t);
        return (t == TAIL) || (t == HEADTAIL);
    endfunction

    function automatic logic is_body(flit_type_e t);
        return (t == DATA) || (t == TAIL);
    endfunction

endpackage

// ==== source/packetizer.sv ====
`timescale 1ns/10ps

module packetizer
    import noc_pkg::*;
#(
    parameter int DATA_WIDTH      = 32,
    parameter int DST_WIDTH       = 4,
    parameter int SRC_WIDTH       = 4,
    parameter int VCH_WIDTH       = 1,
    parameter int NUM_VC          = 2,
    parameter int MAX_PACKET_SIZE = 16,
    parameter int LEN_WIDTH       = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DST_WIDTH-1:0]  dst,
    input  logic [SRC_WIDTH-1:0]  src_id,
    input  logic [VCH_WIDTH-1:0]  vch,
    input  logic [LEN_WIDTH-1:0]  len,
    input  logic [TS_W-1:0]       timestamp,
    input  logic                  start,
    input  logic [NUM_VC-1:0]     ordy,
    output logic [DATA_WIDTH-1:0] idata,
    output logic                  ivalid,
    output logic [VCH_WIDTH-1:0]  ivch,
    output logic                  done,
    output logic                  busy
);

    localparam int TYPE_MSB = DATA_WIDTH - 1;
    localparam int TYPE_LSB = DATA_WIDTH - TYPE_W;
    localparam int DST_MSB  = TYPE_LSB - 1;
    localparam int DST_LSB  = TYPE_LSB - DST_WIDTH;
    localparam int SRC_MSB  = DST_LSB - 1;
    localparam int SRC_LSB  = DST_LSB - SRC_WIDTH;
    localparam int VCH_MSB  = SRC_LSB - 1;
    localparam int VCH_LSB  = SRC_LSB - VCH_WIDTH;

    pktz_state_e state;

    logic [LEN_WIDTH-1:0]  flit_count;     // Index of the next flit
    logic [LEN_WIDTH-1:0]  pkt_len;
    logic [DST_WIDTH-1:0]  pkt_dst;
    logic [SRC_WIDTH-1:0]  pkt_src;
    logic [VCH_WIDTH-1:0]  pkt_vch;
    logic [TS_W-1:0]       pkt_ts;
    logic                  send_now;
    logic                  last_flit;
    logic [DATA_WIDTH-1:0] head_flit;
    logic [DATA_WIDTH-1:0] body_flit;

    // Only the head flit waits on ready, the rest go out back to back
    assign send_now = (state == SEND) ||
                      (((state == INIT) || (state == WAIT)) && ordy[pkt_vch]);

    assign last_flit = (state == SEND) ? (flit_count == pkt_len - 1'b1)
                                       : (pkt_len == LEN_WIDTH'(1));

    always_comb begin
        head_flit = '0;
        head_flit[TYPE_MSB:TYPE_LSB] = (pkt_len == LEN_WIDTH'(1)) ? HEADTAIL : HEAD;
        head_flit[DST_MSB:DST_LSB]   = pkt_dst;
        head_flit[SRC_MSB:SRC_LSB]   = pkt_src;
        head_flit[VCH_MSB:VCH_LSB]   = pkt_vch;
    end

    always_comb begin
        body_flit = '0;
        body_flit[TYPE_MSB:TYPE_LSB]       = last_flit ? TAIL : DATA;
        body_flit[FLIT_ID_MSB:FLIT_ID_LSB] = flit_count[FLIT_ID_W-1:0];
        body_flit[TS_MSB:TS_LSB]           = pkt_ts;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            flit_count <= '0;
            ivalid     <= 1'b0;
            done       <= 1'b0;
            busy       <= 1'b0;
        end else begin
            ivalid <= send_now;
            done   <= send_now && last_flit;   // Lines up with the last ivalid
            unique case (state)
                IDLE: begin
                    if (start) begin
                        state <= INIT;
                        busy  <= 1'b1;
                    end
                end
                INIT, WAIT: begin
                    if (ordy[pkt_vch]) begin
                        flit_count <= LEN_WIDTH'(1);
                        if (last_flit) begin
                            state <= IDLE;
                            busy  <= 1'b0;
                        end else begin
                            state <= SEND;
                        end
                    end else begin
                        state <= WAIT;              // Hold request until room appears
                    end
                end
                SEND: begin
                    flit_count <= flit_count + 1'b1;
                    if (last_flit) begin
                        state <= IDLE;
                        busy  <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Request fields and outgoing flit
    always_ff @(posedge clk) begin
        if ((state == IDLE) && start) begin
            pkt_len <= len;
            pkt_dst <= dst;
            pkt_src <= src_id;
            pkt_vch <= vch;
            pkt_ts  <= timestamp;
        end
        if (send_now) begin
            idata <= (state == SEND) ? body_flit : head_flit;
            ivch  <= pkt_vch;
        end
    end

    a_len_range: assert property (@(posedge clk) disable iff (!rst_n)
        ((state == IDLE) && start) |-> ((len >= 1) && (len <= MAX_PACKET_SIZE)))
        else $error("packetizer: request length %0d out of range", len);

endmodule

// ==== source/vc_input_buffer.sv ====
`timescale 1ns/10ps

module vc_input_buffer
    import noc_pkg::*;
#(
    parameter int DATA_WIDTH      = 32,
    parameter int VCH_WIDTH       = 1,
    parameter int NUM_VC          = 2,
    parameter int MAX_PACKET_SIZE = 16,
    parameter int FIFO_DEPTH      = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] idata,
    input  logic                  ivalid,
    input  logic [VCH_WIDTH-1:0]  ivch,
    input  logic                  drain_en,
    output logic [NUM_VC-1:0]     ordy,
    output logic [DATA_WIDTH-1:0] flit_data,
    output logic                  flit_valid
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [NUM_VC][FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr [NUM_VC];
    logic [PTR_W-1:0]      rd_ptr [NUM_VC];
    logic [CNT_W-1:0]      count [NUM_VC];
    logic [NUM_VC-1:0]     wr_en;
    logic [NUM_VC-1:0]     rd_en;

    logic                  locked;         // Mid-packet, stay on lock_vc
    logic [VCH_WIDTH-1:0]  lock_vc;
    logic [VCH_WIDTH-1:0]  rr_ptr;
    logic [VCH_WIDTH-1:0]  sel;
    logic                  pop;
    flit_type_e            front_type;

    // Round-robin pick among non-empty FIFOs, or the locked channel
    always_comb begin
        int idx;
        logic found;
        sel   = rr_ptr;
        found = 1'b0;
        for (int i = 0; i < NUM_VC; i++) begin
            idx = (int'(rr_ptr) + i) % NUM_VC;
            if (!found && (count[idx] != '0)) begin
                sel   = VCH_WIDTH'(idx);
                found = 1'b1;
            end
        end
        if (locked) begin
            sel = lock_vc;
        end
    end

    assign pop        = drain_en && (count[sel] != '0);
    assign front_type = flit_type_e'(mem[sel][rd_ptr[sel]][DATA_WIDTH-1 -: TYPE_W]);

    always_comb begin
        for (int v = 0; v < NUM_VC; v++) begin
            wr_en[v] = ivalid && (ivch == VCH_WIDTH'(v));
            rd_en[v] = pop && (sel == VCH_WIDTH'(v));
            ordy[v]  = (FIFO_DEPTH - int'(count[v])) >= MAX_PACKET_SIZE;  // Room for a full packet
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < NUM_VC; v++) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                count[v]  <= '0;
            end
            locked     <= 1'b0;
            lock_vc    <= '0;
            rr_ptr     <= '0;
            flit_valid <= 1'b0;
        end else begin
            for (int v = 0; v < NUM_VC; v++) begin
                if (wr_en[v]) begin
                    wr_ptr[v] <= (wr_ptr[v] == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr[v] + 1'b1;
                end
                if (rd_en[v]) begin
                    rd_ptr[v] <= (rd_ptr[v] == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr[v] + 1'b1;
                end
                count[v] <= count[v] + CNT_W'(wr_en[v]) - CNT_W'(rd_en[v]);
            end
            flit_valid <= pop;
            if (pop) begin
                if (ends_packet(front_type)) begin
                    locked <= 1'b0;
                    rr_ptr <= VCH_WIDTH'((int'(sel) + 1) % NUM_VC);  // Next channel gets priority
                end else if (starts_packet(front_type)) begin
                    locked  <= 1'b1;
                    lock_vc <= sel;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ivalid) begin
            mem[ivch][wr_ptr[ivch]] <= idata;
        end
        if (pop) begin
            flit_data <= mem[sel][rd_ptr[sel]];
        end
    end

    if (FIFO_DEPTH < MAX_PACKET_SIZE) begin : g_depth_check
        $error("vc_input_buffer: FIFO_DEPTH below MAX_PACKET_SIZE");
    end

    for (genvar v = 0; v < NUM_VC; v++) begin : g_ovf
        // Ready is only sampled before a head, so this ties ordy to the packet length
        a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
            wr_en[v] |-> (count[v] < FIFO_DEPTH))
            else $error("vc_input_buffer: write to full FIFO %0d", v);
    end

endmodule

// ==== source/depacketizer.sv ====
`timescale 1ns/10ps

module depacketizer
    import noc_pkg::*;
#(
    parameter int DATA_WIDTH      = 32,
    parameter int DST_WIDTH       = 4,
    parameter int SRC_WIDTH       = 4,
    parameter int VCH_WIDTH       = 1,
    parameter int MAX_PACKET_SIZE = 16,
    parameter int LEN_WIDTH       = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] flit_data,
    input  logic                  flit_valid,
    output logic                  pkt_valid,
    output logic [DST_WIDTH-1:0]  pkt_dst,
    output logic [SRC_WIDTH-1:0]  pkt_src,
    output logic [VCH_WIDTH-1:0]  pkt_vch,
    output logic [LEN_WIDTH-1:0]  pkt_len,
    output logic [TS_W-1:0]       pkt_timestamp,
    output logic                  pkt_error
);

    localparam int TYPE_LSB = DATA_WIDTH - TYPE_W;
    localparam int DST_LSB  = TYPE_LSB - DST_WIDTH;
    localparam int SRC_LSB  = DST_LSB - SRC_WIDTH;
    localparam int VCH_LSB  = SRC_LSB - VCH_WIDTH;

    flit_type_e           f_type;
    logic [FLIT_ID_W-1:0] f_id;
    logic [TS_W-1:0]      f_ts;
    logic [DST_WIDTH-1:0] f_dst;
    logic [SRC_WIDTH-1:0] f_src;
    logic [VCH_WIDTH-1:0] f_vch;

    logic                 in_pkt;
    logic [LEN_WIDTH-1:0] flit_cnt;   // Flits seen so far, head included
    logic                 err_acc;
    logic                 ts_seen;
    logic [DST_WIDTH-1:0] hdr_dst;
    logic [SRC_WIDTH-1:0] hdr_src;
    logic [VCH_WIDTH-1:0] hdr_vch;
    logic [TS_W-1:0]      hdr_ts;

    logic                 head_in;
    logic                 body_in;
    logic                 close_in;
    logic                 seq_err;

    assign f_type = flit_type_e'(flit_data[DATA_WIDTH-1 -: TYPE_W]);
    assign f_id   = flit_data[FLIT_ID_MSB:FLIT_ID_LSB];
    assign f_ts   = flit_data[TS_MSB:TS_LSB];
    assign f_dst  = flit_data[DST_LSB +: DST_WIDTH];
    assign f_src  = flit_data[SRC_LSB +: SRC_WIDTH];
    assign f_vch  = flit_data[VCH_LSB +: VCH_WIDTH];

    assign head_in  = flit_valid && starts_packet(f_type);
    assign body_in  = flit_valid && is_body(f_type);
    assign close_in = flit_valid && ends_packet(f_type);

    // Head inside a packet, body outside one, wrong id or too long
    assign seq_err = (head_in && in_pkt) ||
                     (body_in && (!in_pkt ||
                                  (f_id != flit_cnt[FLIT_ID_W-1:0]) ||
                                  (flit_cnt >= MAX_PACKET_SIZE)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_valid <= 1'b0;
            in_pkt    <= 1'b0;
            flit_cnt  <= '0;
            err_acc   <= 1'b0;
            ts_seen   <= 1'b0;
        end else begin
            pkt_valid <= close_in;
            if (head_in) begin
                in_pkt   <= (f_type == HEAD);
                flit_cnt <= LEN_WIDTH'(1);
                err_acc  <= seq_err;
                ts_seen  <= 1'b0;
            end else if (body_in) begin
                flit_cnt <= flit_cnt + 1'b1;
                err_acc  <= err_acc | seq_err;
                ts_seen  <= 1'b1;
                if (f_type == TAIL) begin
                    in_pkt <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (head_in) begin
            hdr_dst <= f_dst;
            hdr_src <= f_src;
            hdr_vch <= f_vch;
        end
        if (body_in && !ts_seen) begin
            hdr_ts <= f_ts;          // First body flit carries the enqueue time
        end
        if (close_in) begin
            if (f_type == HEADTAIL) begin
                pkt_dst       <= f_dst;
                pkt_src       <= f_src;
                pkt_vch       <= f_vch;
                pkt_len       <= LEN_WIDTH'(1);
                pkt_timestamp <= '0;
                pkt_error     <= seq_err;
            end else begin
                pkt_dst       <= hdr_dst;
                pkt_src       <= hdr_src;
                pkt_vch       <= hdr_vch;
                pkt_len       <= flit_cnt + 1'b1;
                pkt_timestamp <= ts_seen ? hdr_ts : f_ts;  // Two-flit packet
                pkt_error     <= err_acc | seq_err;
            end
        end
    end

    // Buffer must keep each channel's packet contiguous
    a_body_in_packet: assert property (@(posedge clk) disable iff (!rst_n)
        body_in |-> in_pkt)
        else $error("depacketizer: body flit outside a packet");

endmodule

// ==== source/noc_endpoint_top.sv ====
`timescale 1ns/10ps

module noc_endpoint_top
    import noc_pkg::*;
#(
    parameter int DATA_WIDTH      = 32,
    parameter int DST_WIDTH       = 4,
    parameter int SRC_WIDTH       = 4,
    parameter int VCH_WIDTH       = 1,
    parameter int NUM_VC          = 2,
    parameter int MAX_PACKET_SIZE = 16,
    parameter int LEN_WIDTH       = 6,
    parameter int FIFO_DEPTH      = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [DST_WIDTH-1:0] dst,
    input  logic [SRC_WIDTH-1:0] src_id,
    input  logic [VCH_WIDTH-1:0] vch,
    input  logic [LEN_WIDTH-1:0] len,
    input  logic [TS_W-1:0]      timestamp,
    input  logic                 drain_en,
    output logic                 busy,
    output logic                 done,
    output logic [NUM_VC-1:0]    link_ready,
    output logic                 pkt_valid,
    output logic [DST_WIDTH-1:0] pkt_dst,
    output logic [SRC_WIDTH-1:0] pkt_src,
    output logic [VCH_WIDTH-1:0] pkt_vch,
    output logic [LEN_WIDTH-1:0] pkt_len,
    output logic [TS_W-1:0]      pkt_timestamp,
    output logic                 pkt_error
);

    logic [DATA_WIDTH-1:0] idata;
    logic                  ivalid;
    logic [VCH_WIDTH-1:0]  ivch;
    logic [DATA_WIDTH-1:0] flit_data;
    logic                  flit_valid;

    // Source side, ready comes straight from the buffer
    packetizer #(
        .DATA_WIDTH      (DATA_WIDTH),
        .DST_WIDTH       (DST_WIDTH),
        .SRC_WIDTH       (SRC_WIDTH),
        .VCH_WIDTH       (VCH_WIDTH),
        .NUM_VC          (NUM_VC),
        .MAX_PACKET_SIZE (MAX_PACKET_SIZE),
        .LEN_WIDTH       (LEN_WIDTH)
    ) u_packetizer (
        .clk, .rst_n, .dst, .src_id, .vch, .len, .timestamp, .start,
        .ordy  (link_ready),
        .idata, .ivalid, .ivch, .done, .busy
    );

    vc_input_buffer #(
        .DATA_WIDTH      (DATA_WIDTH),
        .VCH_WIDTH       (VCH_WIDTH),
        .NUM_VC          (NUM_VC),
        .MAX_PACKET_SIZE (MAX_PACKET_SIZE),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) u_vc_input_buffer (
        .clk, .rst_n, .idata, .ivalid, .ivch, .drain_en,
        .ordy  (link_ready),
        .flit_data, .flit_valid
    );

    depacketizer #(
        .DATA_WIDTH      (DATA_WIDTH),
        .DST_WIDTH       (DST_WIDTH),
        .SRC_WIDTH       (SRC_WIDTH),
        .VCH_WIDTH       (VCH_WIDTH),
        .MAX_PACKET_SIZE (MAX_PACKET_SIZE),
        .LEN_WIDTH       (LEN_WIDTH)
    ) u_depacketizer (
        .clk, .rst_n, .flit_data, .flit_valid,
        .pkt_valid, .pkt_dst, .pkt_src, .pkt_vch, .pkt_len, .pkt_timestamp, .pkt_error
    );

endmodule

// ==== sim/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

// One received packet as the depacketizer reports it
typedef struct packed {
    logic [DST_W-1:0] dst;
    logic [SRC_W-1:0] src;
    logic [VCH_W-1:0] vch;
    logic [LEN_W-1:0] len;
    logic [TS_W-1:0]  ts;
    logic             err;
} pkt_rec_t;

// Expected record for one request
function automatic pkt_rec_t expected_packet(input logic [DST_W-1:0] d,
                                             input logic [SRC_W-1:0] s,
                                             input logic [VCH_W-1:0] v,
                                             input logic [LEN_W-1:0] l,
                                             input logic [TS_W-1:0]  t);
    pkt_rec_t r;
    r.dst = d;
    r.src = s;
    r.vch = v;
    r.len = l;
    r.ts  = (l == LEN_W'(1)) ? '0 : t;    // No body flit, so no enqueue time
    r.err = 1'b0;
    return r;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("mismatch at time %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
endtask

// Received outputs against one expected record
task automatic compare_packet(input pkt_rec_t exp);
    check_value("pkt_dst", 32'(pkt_dst), 32'(exp.dst));
    check_value("pkt_src", 32'(pkt_src), 32'(exp.src));
    check_value("pkt_vch", 32'(pkt_vch), 32'(exp.vch));
    check_value("pkt_len", 32'(pkt_len), 32'(exp.len));
    check_value("pkt_timestamp", 32'(pkt_timestamp), 32'(exp.ts));
    check_value("pkt_error", 32'(pkt_error), 32'(exp.err));
endtask

`endif

// ==== sim/tb_noc_endpoint.sv ====
`timescale 1ns/10ps

module tb_noc_endpoint
    import noc_pkg::*;
;

    localparam int DATA_W      = 32;
    localparam int DST_W       = 4;
    localparam int SRC_W       = 4;
    localparam int VCH_W       = 1;
    localparam int NUM_VC      = 2;
    localparam int MAX_PKT     = 16;
    localparam int LEN_W       = 6;
    localparam int FIFO_DEPTH  = 32;
    localparam int N_RANDOM    = 200;
    localparam int N_ISSUED    = 1 + 3 + 3 + N_RANDOM;
    localparam int CYCLE_LIMIT = 40 * N_ISSUED + 2000;
    localparam int WAIT_LIMIT  = 200;   // Per wait for done or for the scoreboard

    logic             clk;
    logic             rst_n;
    logic             start;
    logic [DST_W-1:0] dst;
    logic [SRC_W-1:0] src_id;
    logic [VCH_W-1:0] vch;
    logic [LEN_W-1:0] len;
    logic [TS_W-1:0]  timestamp;
    logic             drain_en;
    logic             busy;
    logic             done;
    logic [NUM_VC-1:0] link_ready;
    logic             pkt_valid;
    logic [DST_W-1:0] pkt_dst;
    logic [SRC_W-1:0] pkt_src;
    logic [VCH_W-1:0] pkt_vch;
    logic [LEN_W-1:0] pkt_len;
    logic [TS_W-1:0]  pkt_timestamp;
    logic             pkt_error;

    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cyc = 0;          // Advances on the falling edge
    int start_cyc = 0;
    int test_lens [3] = '{2, 7, 16};

    `include "tb_ref.svh"

    pkt_rec_t exp_q [$];
    pkt_rec_t exp_rec;

    noc_endpoint_top #(
        .DATA_WIDTH      (DATA_W),
        .DST_WIDTH       (DST_W),
        .SRC_WIDTH       (SRC_W),
        .VCH_WIDTH       (VCH_W),
        .NUM_VC          (NUM_VC),
        .MAX_PACKET_SIZE (MAX_PKT),
        .LEN_WIDTH       (LEN_W),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) DUT (
        .clk, .rst_n, .start, .dst, .src_id, .vch, .len, .timestamp, .drain_en,
        .busy, .done, .link_ready,
        .pkt_valid, .pkt_dst, .pkt_src, .pkt_vch, .pkt_len, .pkt_timestamp, .pkt_error
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests %0d run, %0d failed, %0d checks, %0d errors",
                     tests_run, tests_failed, checks, errors + 1);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Scoreboard, packets come back in issue order
    always @(negedge clk) begin
        if (rst_n && pkt_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("error at time %0t: packet received while none was expected", $time);
            end else begin
                exp_rec = exp_q.pop_front();
                compare_packet(exp_rec);
            end
        end
    end

    task automatic issue_packet(input logic [DST_W-1:0] d, input logic [SRC_W-1:0] s,
                                input logic [VCH_W-1:0] v, input logic [LEN_W-1:0] l,
                                input logic [TS_W-1:0] t);
        @(posedge clk);
        start     <= 1'b1;
        dst       <= d;
        src_id    <= s;
        vch       <= v;
        len       <= l;
        timestamp <= t;
        start_cyc = cyc;
        exp_q.push_back(expected_packet(d, s, v, l, t));
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Busy must hold until the done pulse and drop with it
    task automatic wait_done(output int latency);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        latency = -1;
        while (!seen && (n < WAIT_LIMIT)) begin
            @(negedge clk);
            n++;
            if (done) begin
                seen = 1'b1;
                latency = cyc - start_cyc;
                check_value("busy", 32'(busy), 32'(0));
            end else begin
                check_value("busy", 32'(busy), 32'(1));
            end
        end
        if (!seen) begin
            errors++;
            $display("error at time %0t: no done within %0d cycles", $time, WAIT_LIMIT);
        end
    endtask

    task automatic wait_empty();
        int n;
        n = 0;
        while ((exp_q.size() != 0) && (n < WAIT_LIMIT)) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("error at time %0t: %0d packets never arrived", $time, exp_q.size());
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int lat;
        int err0;
        logic [LEN_W-1:0] l;
        void'($urandom(32'h6636));
        rst_n     = 1'b0;
        start     = 1'b0;
        dst       = '0;
        src_id    = '0;
        vch       = '0;
        len       = '0;
        timestamp = '0;
        drain_en  = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        err0 = errors;
        @(negedge clk);
        check_value("busy", 32'(busy), 32'(0));
        check_value("done", 32'(done), 32'(0));
        check_value("pkt_valid", 32'(pkt_valid), 32'(0));
        check_value("link_ready", 32'(link_ready), 32'({NUM_VC{1'b1}}));
        finish_test("reset_state", err0);

        err0 = errors;
        issue_packet(4'h3, 4'hA, 1'b1, LEN_W'(1), 16'h5A5A);
        wait_done(lat);
        wait_empty();
        finish_test("single_flit", err0);

        err0 = errors;
        foreach (test_lens[i]) begin
            issue_packet(DST_W'(i + 4), SRC_W'(9), VCH_W'(i % NUM_VC), LEN_W'(test_lens[i]),
                         TS_W'(16'h1000 + i));
            wait_done(lat);
            check_value("done latency", 32'(lat), 32'(test_lens[i] + 1));
        end
        wait_empty();
        finish_test("done_timing", err0);

        // Channel 0 fills up with the drain stopped
        err0 = errors;
        @(posedge clk);
        drain_en <= 1'b0;
        issue_packet(4'h5, 4'h2, 1'b0, LEN_W'(16), 16'hBEEF);
        wait_done(lat);
        issue_packet(4'h6, 4'h2, 1'b0, LEN_W'(16), 16'hCAFE);
        wait_done(lat);
        @(negedge clk);
        check_value("link_ready[0]", 32'(link_ready[0]), 32'(0));
        issue_packet(4'h7, 4'h2, 1'b0, LEN_W'(8), 16'h1234);
        repeat (30) begin
            @(negedge clk);
            check_value("busy", 32'(busy), 32'(1));
            check_value("done", 32'(done), 32'(0));
        end
        @(posedge clk);
        drain_en <= 1'b1;
        wait_done(lat);
        wait_empty();
        finish_test("backpressure", err0);

        err0 = errors;
        repeat (N_RANDOM) begin
            l = LEN_W'($urandom % MAX_PKT + 1);
            issue_packet(DST_W'($urandom), SRC_W'($urandom), VCH_W'($urandom % NUM_VC), l,
                         TS_W'($urandom));
            wait_done(lat);
        end
        wait_empty();
        finish_test("random_packets", err0);

        $display("tests %0d run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+sim
source/noc_pkg.sv
source/packetizer.sv
source/vc_input_buffer.sv
source/depacketizer.sv
source/noc_endpoint_top.sv
sim/tb_noc_endpoint.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the NoC endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_noc_endpoint -f flist.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

output=$(./obj_dir/Vtb_noc_endpoint 2>&1)
run_status=$?
echo "$output"

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
